// File: logic/alu.sv
/* Combinational 64-bit integer ALU */
`timescale 1ns/100ps
`include "ex_defs.svh"

module alu (
  input  ex_pkg::word_t     opa,
  input  ex_pkg::word_t     opb,
  input  ex_pkg::alu_func_t func,
  output ex_pkg::word_t     result
);

  always_comb
  begin
    case (func)
      `ALU_ADDQ:   result = opa + opb;
      `ALU_SUBQ:   result = opa - opb;
      `ALU_AND:    result = opa & opb;
      `ALU_BIC:    result = opa & ~opb;   // And with complement
      `ALU_BIS:    result = opa | opb;
      `ALU_XOR:    result = opa ^ opb;
      `ALU_SRL:    result = opa >> opb[5:0];
      `ALU_SLL:    result = opa << opb[5:0];
      `ALU_SRA:    result = $signed(opa) >>> opb[5:0];
      // Compares give 0 or 1
      `ALU_CMPEQ:  result = {63'd0, opa == opb};
      `ALU_CMPLT:  result = {63'd0, $signed(opa) < $signed(opb)};
      `ALU_CMPULT: result = {63'd0, opa < opb};
      default:     result = '0;
    endcase
  end

endmodule

// File: logic/ex_defs.svh
/*
 * Execute stage sizes, ALU function codes, operand selects
 * and branch-condition codes
 */
`ifndef EX_DEFS_SVH
`define EX_DEFS_SVH

`define EX_LANES     2  // Issue lanes
`define MULT_STAGES  4  // Multiplier pipeline depth
`define HISTORY_BITS 8  // Pattern history index width

//////////////////////////////
// ALU function codes
`define ALU_ADDQ   5'h00
`define ALU_SUBQ   5'h01
`define ALU_AND    5'h02
`define ALU_BIC    5'h03
`define ALU_BIS    5'h04
`define ALU_XOR    5'h06
`define ALU_SRL    5'h08
`define ALU_SLL    5'h09
`define ALU_SRA    5'h0a
`define ALU_MULQ   5'h0b  // Routed to the multiplier
`define ALU_CMPEQ  5'h0c
`define ALU_CMPLT  5'h0d
`define ALU_CMPULT 5'h0f

//////////////////////////////
// Operand selects
`define OPA_IS_REGA     2'h0
`define OPA_IS_MEM_DISP 2'h1
`define OPA_IS_NPC      2'h2
`define OPA_IS_NOT3     2'h3
`define OPB_IS_REGB     2'h0
`define OPB_IS_ALU_IMM  2'h1
`define OPB_IS_BR_DISP  2'h2

//////////////////////////////
// Branch conditions, instruction bits 28:26
`define BR_LBC 3'b000
`define BR_EQ  3'b001
`define BR_LT  3'b010
`define BR_LE  3'b011
`define BR_LBS 3'b100
`define BR_NE  3'b101
`define BR_GE  3'b110
`define BR_GT  3'b111

`endif

// File: logic/ex_lane.sv
/* One execute lane: operand muxes, ALU, multiplier, branch resolve, LSQ outputs */
`timescale 1ns/100ps
`include "ex_defs.svh"

module ex_lane (
  input  logic               clock,
  input  logic               rst_n,
  input  logic               l_valid,
  input  ex_pkg::word_t      l_npc,
  input  ex_pkg::word_t      l_ppc,
  input  ex_pkg::pht_idx_t   l_pht_idx,
  input  ex_pkg::instr_t     l_ir,
  input  ex_pkg::reg_idx_t   l_dest_reg,
  input  ex_pkg::word_t      l_rega,
  input  ex_pkg::word_t      l_regb,
  input  ex_pkg::opa_sel_t   l_opa_select,
  input  ex_pkg::opb_sel_t   l_opb_select,
  input  ex_pkg::alu_func_t  l_alu_func,
  input  logic               l_cond_branch,
  input  logic               l_uncond_branch,
  input  logic               l_rd_mem,
  input  logic               l_wr_mem,
  input  logic               mult_freeze,
  output logic               alu_valid,
  output ex_pkg::word_t      alu_result,
  output ex_pkg::reg_idx_t   dest,
  output ex_pkg::word_t      npc,
  output ex_pkg::br_result_t br_result,
  output logic               mispredict,
  output ex_pkg::pht_idx_t   pht_idx,
  output logic               mult_issue,   // Mult entry waiting in the latch
  output logic               mult_valid,
  output ex_pkg::word_t      mult_result,
  output ex_pkg::reg_idx_t   mult_dest,
  output ex_pkg::word_t      mult_npc,
  output logic               lsq_valid,
  output ex_pkg::reg_idx_t   lsq_tag,
  output ex_pkg::word_t      lsq_address,
  output ex_pkg::word_t      lsq_value
);
  import ex_pkg::*;

  word_t mem_disp, br_disp, alu_imm;
  word_t opa, opb;
  logic  is_mem, br_cond, taken;

  // Immediates from the instruction word
  assign mem_disp = {{48{l_ir[15]}}, l_ir[15:0]};
  assign br_disp  = {{41{l_ir[20]}}, l_ir[20:0], 2'b00};  // Word displacement
  assign alu_imm  = {56'd0, l_ir[20:13]};

  assign is_mem     = l_rd_mem | l_wr_mem;
  assign mult_issue = l_valid && (l_alu_func == `ALU_MULQ);
  assign alu_valid  = l_valid && !is_mem && (l_alu_func != `ALU_MULQ);

  //////////////////////////////
  // Operand muxes
  always_comb
  begin
    case (l_opa_select)
      `OPA_IS_REGA:     opa = l_rega;
      `OPA_IS_MEM_DISP: opa = mem_disp;
      `OPA_IS_NPC:      opa = l_npc;
      default:          opa = ~64'h3;
    endcase
    case (l_opb_select)
      `OPB_IS_REGB:    opb = l_regb;
      `OPB_IS_ALU_IMM: opb = alu_imm;
      `OPB_IS_BR_DISP: opb = br_disp;
      default:         opb = '0;   // Unused code
    endcase
  end

  alu u_alu (.opa(opa), .opb(opb), .func(l_alu_func), .result(alu_result));

  mult u_mult (
    .clock, .rst_n,
    .valid_in(mult_issue), .freeze(mult_freeze),
    .mplier(opa), .mcand(opb), .dest_in(l_dest_reg), .npc_in(l_npc),
    .valid_out(mult_valid), .product(mult_result),
    .dest_out(mult_dest), .npc_out(mult_npc)
  );

  //////////////////////////////
  // Branch resolve, condition always on rega
  always_comb
  begin
    case (l_ir[28:26])
      `BR_LBC: br_cond = !l_rega[0];
      `BR_EQ:  br_cond = (l_rega == '0);
      `BR_LT:  br_cond = l_rega[63];
      `BR_LE:  br_cond = l_rega[63] || (l_rega == '0);
      `BR_LBS: br_cond = l_rega[0];
      `BR_NE:  br_cond = (l_rega != '0);
      `BR_GE:  br_cond = !l_rega[63];
      default: br_cond = !l_rega[63] && (l_rega != '0);  // GT
    endcase
  end

  assign taken      = l_uncond_branch || (l_cond_branch && br_cond);
  assign mispredict = taken && (alu_result != l_ppc);
  assign br_result  = {l_cond_branch | l_uncond_branch, taken};
  assign dest       = l_dest_reg;
  assign npc        = l_npc;
  assign pht_idx    = l_pht_idx;

  // LSQ gets the effective address and store data
  assign lsq_valid   = l_valid && is_mem;
  assign lsq_tag     = l_dest_reg;
  assign lsq_address = alu_result;
  assign lsq_value   = l_rega;

  a_mem_kind: assert property (@(posedge clock) disable iff (!rst_n)
    l_valid |-> !(l_rd_mem && l_wr_mem))
    else $error("Load and store set on one entry");

endmodule

// File: logic/ex_pkg.sv
/* Vector types shared by the execute stage and its testbench */
`include "ex_defs.svh"

package ex_pkg;

  typedef logic [63:0] word_t;     // Data, address and PC
  typedef logic [31:0] instr_t;
  typedef logic [4:0]  reg_idx_t;  // Dest register or load tag
  typedef logic [4:0]  alu_func_t;
  typedef logic [1:0]  opa_sel_t;
  typedef logic [1:0]  opb_sel_t;

  typedef logic [`HISTORY_BITS-1:0] pht_idx_t;

  // Upper bit marks a branch, lower bit marks taken
  typedef logic [1:0] br_result_t;

endpackage

// File: logic/ex_stage.sv
/* Execute stage top: ID/EX latch, execute lanes and result arbiter */
`timescale 1ns/100ps
`include "ex_defs.svh"

module ex_stage (
  input  logic               clock,
  input  logic               rst_n,
  input  logic               valid_in         [`EX_LANES],
  input  ex_pkg::word_t      npc              [`EX_LANES],
  input  ex_pkg::word_t      ppc              [`EX_LANES],
  input  ex_pkg::pht_idx_t   pht_idx          [`EX_LANES],
  input  ex_pkg::instr_t     ir               [`EX_LANES],
  input  ex_pkg::reg_idx_t   dest_reg         [`EX_LANES],
  input  ex_pkg::word_t      rega             [`EX_LANES],
  input  ex_pkg::word_t      regb             [`EX_LANES],
  input  ex_pkg::opa_sel_t   opa_select       [`EX_LANES],
  input  ex_pkg::opb_sel_t   opb_select       [`EX_LANES],
  input  ex_pkg::alu_func_t  alu_func         [`EX_LANES],
  input  logic               cond_branch      [`EX_LANES],
  input  logic               uncond_branch    [`EX_LANES],
  input  logic               rd_mem           [`EX_LANES],
  input  logic               wr_mem           [`EX_LANES],
  input  logic               mem_valid,
  input  ex_pkg::reg_idx_t   mem_tag,
  input  ex_pkg::word_t      mem_value,
  output logic               stall_bus        [`EX_LANES],
  output logic               ex_valid         [`EX_LANES],
  output ex_pkg::word_t      ex_npc           [`EX_LANES],
  output ex_pkg::reg_idx_t   ex_dest_reg      [`EX_LANES],
  output ex_pkg::word_t      ex_result        [`EX_LANES],
  output logic               ex_mispredict    [`EX_LANES],
  output ex_pkg::br_result_t ex_branch_result [`EX_LANES],
  output ex_pkg::pht_idx_t   ex_pht_idx       [`EX_LANES],
  output logic               lsq_valid        [`EX_LANES],
  output ex_pkg::reg_idx_t   lsq_tag          [`EX_LANES],
  output ex_pkg::word_t      lsq_address      [`EX_LANES],
  output ex_pkg::word_t      lsq_value        [`EX_LANES]
);
  import ex_pkg::*;

  // Latched issue fields
  logic       l_valid [`EX_LANES], l_cond_branch [`EX_LANES], l_uncond_branch [`EX_LANES];
  logic       l_rd_mem [`EX_LANES], l_wr_mem [`EX_LANES];
  word_t      l_npc [`EX_LANES], l_ppc [`EX_LANES], l_rega [`EX_LANES], l_regb [`EX_LANES];
  pht_idx_t   l_pht_idx [`EX_LANES];
  instr_t     l_ir [`EX_LANES];
  reg_idx_t   l_dest_reg [`EX_LANES];
  opa_sel_t   l_opa_select [`EX_LANES];
  opb_sel_t   l_opb_select [`EX_LANES];
  alu_func_t  l_alu_func [`EX_LANES];

  // Lane results toward the arbiter
  logic       alu_valid [`EX_LANES], mispredict [`EX_LANES], mult_freeze [`EX_LANES];
  logic       mult_issue [`EX_LANES], mult_valid [`EX_LANES];
  word_t      alu_result [`EX_LANES], lane_npc [`EX_LANES];
  word_t      mult_result [`EX_LANES], mult_npc [`EX_LANES];
  reg_idx_t   lane_dest [`EX_LANES], mult_dest [`EX_LANES];
  br_result_t br_result [`EX_LANES];
  pht_idx_t   lane_pht_idx [`EX_LANES];

  id_ex_latch u_latch (.*);

  for (genvar i = 0; i < `EX_LANES; i++)
  begin : g_lane
    ex_lane u_lane (
      .clock, .rst_n,
      .l_valid(l_valid[i]), .l_npc(l_npc[i]), .l_ppc(l_ppc[i]),
      .l_pht_idx(l_pht_idx[i]), .l_ir(l_ir[i]), .l_dest_reg(l_dest_reg[i]),
      .l_rega(l_rega[i]), .l_regb(l_regb[i]),
      .l_opa_select(l_opa_select[i]), .l_opb_select(l_opb_select[i]),
      .l_alu_func(l_alu_func[i]), .l_cond_branch(l_cond_branch[i]),
      .l_uncond_branch(l_uncond_branch[i]),
      .l_rd_mem(l_rd_mem[i]), .l_wr_mem(l_wr_mem[i]),
      .mult_freeze(mult_freeze[i]),
      .alu_valid(alu_valid[i]), .alu_result(alu_result[i]),
      .dest(lane_dest[i]), .npc(lane_npc[i]), .br_result(br_result[i]),
      .mispredict(mispredict[i]), .pht_idx(lane_pht_idx[i]),
      .mult_issue(mult_issue[i]), .mult_valid(mult_valid[i]),
      .mult_result(mult_result[i]), .mult_dest(mult_dest[i]), .mult_npc(mult_npc[i]),
      .lsq_valid(lsq_valid[i]), .lsq_tag(lsq_tag[i]),
      .lsq_address(lsq_address[i]), .lsq_value(lsq_value[i])
    );
  end

  // Lane fields renamed where they clash with issue ports
  result_arbiter u_arbiter (
    .dest(lane_dest), .npc(lane_npc), .pht_idx(lane_pht_idx),
    .*
  );

endmodule

// File: logic/id_ex_latch.sv
/* ID/EX pipeline register for all issue lanes, held per lane on stall */
`timescale 1ns/100ps
`include "ex_defs.svh"

module id_ex_latch (
  input  logic                 clock,
  input  logic                 rst_n,
  input  logic                 valid_in        [`EX_LANES],
  input  ex_pkg::word_t        npc             [`EX_LANES],
  input  ex_pkg::word_t        ppc             [`EX_LANES],
  input  ex_pkg::pht_idx_t     pht_idx         [`EX_LANES],
  input  ex_pkg::instr_t       ir              [`EX_LANES],
  input  ex_pkg::reg_idx_t     dest_reg        [`EX_LANES],
  input  ex_pkg::word_t        rega            [`EX_LANES],
  input  ex_pkg::word_t        regb            [`EX_LANES],
  input  ex_pkg::opa_sel_t     opa_select      [`EX_LANES],
  input  ex_pkg::opb_sel_t     opb_select      [`EX_LANES],
  input  ex_pkg::alu_func_t    alu_func        [`EX_LANES],
  input  logic                 cond_branch     [`EX_LANES],
  input  logic                 uncond_branch   [`EX_LANES],
  input  logic                 rd_mem          [`EX_LANES],
  input  logic                 wr_mem          [`EX_LANES],
  input  logic                 stall_bus       [`EX_LANES],
  output logic                 l_valid         [`EX_LANES],
  output ex_pkg::word_t        l_npc           [`EX_LANES],
  output ex_pkg::word_t        l_ppc           [`EX_LANES],
  output ex_pkg::pht_idx_t     l_pht_idx       [`EX_LANES],
  output ex_pkg::instr_t       l_ir            [`EX_LANES],
  output ex_pkg::reg_idx_t     l_dest_reg      [`EX_LANES],
  output ex_pkg::word_t        l_rega          [`EX_LANES],
  output ex_pkg::word_t        l_regb          [`EX_LANES],
  output ex_pkg::opa_sel_t     l_opa_select    [`EX_LANES],
  output ex_pkg::opb_sel_t     l_opb_select    [`EX_LANES],
  output ex_pkg::alu_func_t    l_alu_func      [`EX_LANES],
  output logic                 l_cond_branch   [`EX_LANES],
  output logic                 l_uncond_branch [`EX_LANES],
  output logic                 l_rd_mem        [`EX_LANES],
  output logic                 l_wr_mem        [`EX_LANES]
);

  always_ff @(posedge clock or negedge rst_n)
  begin
    if (!rst_n)
      for (int i = 0; i < `EX_LANES; i++)
        l_valid[i] <= 1'b0;
    else
      for (int i = 0; i < `EX_LANES; i++)
        if (!stall_bus[i])
          l_valid[i] <= valid_in[i];
  end

  // Payload follows the valid bit, held on the same stall
  always_ff @(posedge clock)
  begin
    for (int i = 0; i < `EX_LANES; i++)
    begin
      if (!stall_bus[i])
      begin
        l_npc[i]           <= npc[i];
        l_ppc[i]           <= ppc[i];
        l_pht_idx[i]       <= pht_idx[i];
        l_ir[i]            <= ir[i];
        l_dest_reg[i]      <= dest_reg[i];
        l_rega[i]          <= rega[i];
        l_regb[i]          <= regb[i];
        l_opa_select[i]    <= opa_select[i];
        l_opb_select[i]    <= opb_select[i];
        l_alu_func[i]      <= alu_func[i];
        l_cond_branch[i]   <= cond_branch[i];
        l_uncond_branch[i] <= uncond_branch[i];
        l_rd_mem[i]        <= rd_mem[i];
        l_wr_mem[i]        <= wr_mem[i];
      end
    end
  end

  for (genvar i = 0; i < `EX_LANES; i++)
  begin : g_hold_chk
    // A stalled entry must reach the lane again unchanged
    a_hold: assert property (@(posedge clock) disable iff (!rst_n)
      stall_bus[i] |=> $stable(l_valid[i]) && $stable(l_ir[i])
                       && $stable(l_rega[i]) && $stable(l_regb[i]))
      else $error("Lane %0d entry changed while stalled", i);
  end

endmodule

// File: logic/mult.sv
/* Pipelined 64-bit multiplier, one mplier slice per stage, with freeze */
`timescale 1ns/100ps
`include "ex_defs.svh"

module mult (
  input  logic             clock,
  input  logic             rst_n,
  input  logic             valid_in,
  input  logic             freeze,
  input  ex_pkg::word_t    mplier,
  input  ex_pkg::word_t    mcand,
  input  ex_pkg::reg_idx_t dest_in,
  input  ex_pkg::word_t    npc_in,
  output logic             valid_out,
  output ex_pkg::word_t    product,
  output ex_pkg::reg_idx_t dest_out,
  output ex_pkg::word_t    npc_out
);
  import ex_pkg::*;

  localparam int SLICE = 64 / `MULT_STAGES;  // mplier bits per stage

  logic     st_valid  [`MULT_STAGES];
  word_t    st_sum    [`MULT_STAGES];     // Running low 64 bits
  word_t    st_mplier [`MULT_STAGES-1];   // Remaining slices
  word_t    st_mcand  [`MULT_STAGES-1];   // Shifted to slice weight
  reg_idx_t st_dest   [`MULT_STAGES];
  word_t    st_npc    [`MULT_STAGES];

  function automatic word_t partial(input word_t mp, input word_t mc);
    return {{(64-SLICE){1'b0}}, mp[SLICE-1:0]} * mc;
  endfunction

  always_ff @(posedge clock or negedge rst_n)
  begin
    if (!rst_n)
      for (int j = 0; j < `MULT_STAGES; j++)
        st_valid[j] <= 1'b0;
    else if (!freeze)
    begin
      st_valid[0] <= valid_in;
      for (int j = 1; j < `MULT_STAGES; j++)
        st_valid[j] <= st_valid[j-1];
    end
  end

  always_ff @(posedge clock)
  begin
    if (!freeze)
    begin
      st_sum[0]    <= partial(mplier, mcand);
      st_mplier[0] <= mplier >> SLICE;
      st_mcand[0]  <= mcand << SLICE;
      st_dest[0]   <= dest_in;
      st_npc[0]    <= npc_in;
      for (int j = 1; j < `MULT_STAGES; j++)
      begin
        st_sum[j]  <= st_sum[j-1] + partial(st_mplier[j-1], st_mcand[j-1]);
        st_dest[j] <= st_dest[j-1];
        st_npc[j]  <= st_npc[j-1];
      end
      for (int j = 1; j < `MULT_STAGES-1; j++)
      begin
        st_mplier[j] <= st_mplier[j-1] >> SLICE;
        st_mcand[j]  <= st_mcand[j-1] << SLICE;
      end
    end
  end

  assign valid_out = st_valid[`MULT_STAGES-1];
  assign product   = st_sum[`MULT_STAGES-1];
  assign dest_out  = st_dest[`MULT_STAGES-1];
  assign npc_out   = st_npc[`MULT_STAGES-1];

endmodule

// File: logic/result_arbiter.sv
/* Writeback slot arbitration per lane: memory, then multiplier, then ALU */
`timescale 1ns/100ps
`include "ex_defs.svh"

module result_arbiter (
  input  logic               clock,
  input  logic               rst_n,
  input  logic               alu_valid        [`EX_LANES],
  input  ex_pkg::word_t      alu_result       [`EX_LANES],
  input  ex_pkg::reg_idx_t   dest             [`EX_LANES],
  input  ex_pkg::word_t      npc              [`EX_LANES],
  input  ex_pkg::br_result_t br_result        [`EX_LANES],
  input  logic               mispredict       [`EX_LANES],
  input  ex_pkg::pht_idx_t   pht_idx          [`EX_LANES],
  input  logic               mult_issue       [`EX_LANES],
  input  logic               mult_valid       [`EX_LANES],
  input  ex_pkg::word_t      mult_result      [`EX_LANES],
  input  ex_pkg::reg_idx_t   mult_dest        [`EX_LANES],
  input  ex_pkg::word_t      mult_npc         [`EX_LANES],
  input  logic               mem_valid,
  input  ex_pkg::reg_idx_t   mem_tag,
  input  ex_pkg::word_t      mem_value,
  output logic               stall_bus        [`EX_LANES],
  output logic               mult_freeze      [`EX_LANES],
  output logic               ex_valid         [`EX_LANES],
  output ex_pkg::word_t      ex_npc           [`EX_LANES],
  output ex_pkg::reg_idx_t   ex_dest_reg      [`EX_LANES],
  output ex_pkg::word_t      ex_result        [`EX_LANES],
  output logic               ex_mispredict    [`EX_LANES],
  output ex_pkg::br_result_t ex_branch_result [`EX_LANES],
  output ex_pkg::pht_idx_t   ex_pht_idx       [`EX_LANES]
);

  localparam int LAST = `EX_LANES - 1;  // Only lane with memory returns

  logic mem_gnt [`EX_LANES];
  logic mult_gnt [`EX_LANES];
  logic alu_gnt [`EX_LANES];

  always_comb
  begin
    for (int i = 0; i < `EX_LANES; i++)
    begin
      mem_gnt[i]     = (i == LAST) && mem_valid;
      mult_gnt[i]    = mult_valid[i] && !mem_gnt[i];
      alu_gnt[i]     = alu_valid[i] && !mem_gnt[i] && !mult_valid[i];
      mult_freeze[i] = mem_gnt[i];
      // Losing ALU op retries, mult entry waits out the freeze
      stall_bus[i]   = (alu_valid[i] && !alu_gnt[i]) || (mult_issue[i] && mult_freeze[i]);
    end
  end

  always_ff @(posedge clock or negedge rst_n)
  begin
    if (!rst_n)
      for (int i = 0; i < `EX_LANES; i++)
        ex_valid[i] <= 1'b0;
    else
      for (int i = 0; i < `EX_LANES; i++)
        ex_valid[i] <= mem_gnt[i] || mult_gnt[i] || alu_gnt[i];
  end

  //////////////////////////////
  // Winner payload
  always_ff @(posedge clock)
  begin
    for (int i = 0; i < `EX_LANES; i++)
    begin
      ex_pht_idx[i] <= pht_idx[i];
      if (mem_gnt[i])
      begin
        ex_npc[i]           <= '0;
        ex_dest_reg[i]      <= mem_tag;
        ex_result[i]        <= mem_value;
        ex_mispredict[i]    <= 1'b0;
        ex_branch_result[i] <= 2'b00;
      end
      else if (mult_gnt[i])
      begin
        ex_npc[i]           <= mult_npc[i];
        ex_dest_reg[i]      <= mult_dest[i];
        ex_result[i]        <= mult_result[i];
        ex_mispredict[i]    <= 1'b0;
        ex_branch_result[i] <= 2'b00;   // Never a branch
      end
      else
      begin
        ex_npc[i]           <= npc[i];
        ex_dest_reg[i]      <= dest[i];
        ex_result[i]        <= alu_result[i];
        ex_mispredict[i]    <= mispredict[i];
        ex_branch_result[i] <= br_result[i];
      end
    end
  end

  for (genvar i = 0; i < `EX_LANES; i++)
  begin : g_arb_chk
    a_one_gnt: assert property (@(posedge clock) disable iff (!rst_n)
      $onehot0({mem_gnt[i], mult_gnt[i], alu_gnt[i]}))
      else $error("Lane %0d slot granted twice", i);
    // Frozen product must still be there next cycle
    a_freeze_hold: assert property (@(posedge clock) disable iff (!rst_n)
      mult_freeze[i] && mult_valid[i] |=> mult_valid[i] && $stable(mult_result[i]))
      else $error("Lane %0d product lost under freeze", i);
  end

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the execute stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f sources.f --top-module ex_stage_tb \
  --Mdir obj_dir -o ex_stage_sim \
  && ./obj_dir/ex_stage_sim \
  || exit 1

// File: sources.f
+incdir+logic
logic/ex_pkg.sv
logic/id_ex_latch.sv
logic/alu.sv
logic/mult.sv
logic/ex_lane.sv
logic/result_arbiter.sv
logic/ex_stage.sv
verif/ex_stage_tb.sv

// File: verif/ex_stage_tb.sv
/* Execute stage testbench with random stimulus, a reference model,
 * result queues checked by concurrent assertions and a watchdog */
`timescale 1ns/100ps
`include "ex_defs.svh"

module ex_stage_tb;
  import ex_pkg::*;

  localparam int N_OPS = 2*20 + 2*16 + 8 + 2*6 + 3;  // Ops issued over all phases
  localparam longint LIMIT_NS = (N_OPS * (`MULT_STAGES + 4) + 40) * 20;

  typedef struct packed {
    logic [1:0] kind;  // 0 ALU, 1 mult, 2 memory return
    reg_idx_t   dest;
    word_t      npc;
    word_t      result;
    br_result_t br;
    logic       mis;
    pht_idx_t   pht;
    logic       exact;
    int         due;
  } exp_t;

  logic clock, rst_n;
  logic valid_in [`EX_LANES], cond_branch [`EX_LANES], uncond_branch [`EX_LANES];
  logic rd_mem [`EX_LANES], wr_mem [`EX_LANES], stall_bus [`EX_LANES];
  word_t npc [`EX_LANES], ppc [`EX_LANES], rega [`EX_LANES], regb [`EX_LANES];
  pht_idx_t pht_idx [`EX_LANES];
  instr_t ir [`EX_LANES];
  reg_idx_t dest_reg [`EX_LANES];
  opa_sel_t opa_select [`EX_LANES];
  opb_sel_t opb_select [`EX_LANES];
  alu_func_t alu_func [`EX_LANES];
  logic mem_valid;
  reg_idx_t mem_tag;
  word_t mem_value;
  logic ex_valid [`EX_LANES], ex_mispredict [`EX_LANES], lsq_valid [`EX_LANES];
  word_t ex_npc [`EX_LANES], ex_result [`EX_LANES];
  word_t lsq_address [`EX_LANES], lsq_value [`EX_LANES];
  reg_idx_t ex_dest_reg [`EX_LANES], lsq_tag [`EX_LANES];
  br_result_t ex_branch_result [`EX_LANES];
  pht_idx_t ex_pht_idx [`EX_LANES];

  exp_t  exp_q [`EX_LANES][$];
  logic  head_ok [`EX_LANES];
  string err_msg [`EX_LANES];
  word_t lcg_state = 64'd61;
  int    cyc = 0;
  logic  exact_mode, saw_stall;
  word_t lsq_exp_addr, lsq_exp_val;
  reg_idx_t lsq_exp_tag;

  ex_stage dut0 (.*);

  initial
  begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  always @(posedge clock) cyc <= cyc + 1;

  task automatic fail_now(input string msg);
    $display("** Error at %0t: %s", $time, msg);
    $display("Verification failed");
    $fatal(1);
  endtask

  initial
  begin
    #(LIMIT_NS);
    $display("Timeout: the run did not finish in %0d ns", LIMIT_NS);
    $display("Verification failed");
    $fatal(1);
  end

  //////////////////////////////
  // Reference model
  function word_t next_random();
    lcg_state = lcg_state * 64'd6364136223846793005 + 64'd1442695040888963407;
    return lcg_state;
  endfunction

  function int random_below(input int n);
    word_t r;
    r = next_random();
    return int'(r[63:40] % n);  // High bits are the better ones
  endfunction

  function word_t alu_model(input alu_func_t f, input word_t a, input word_t b);
    case (f)
      `ALU_ADDQ:   return a + b;
      `ALU_SUBQ:   return a - b;
      `ALU_AND:    return a & b;
      `ALU_BIC:    return a & ~b;
      `ALU_BIS:    return a | b;
      `ALU_XOR:    return a ^ b;
      `ALU_SRL:    return a >> b[5:0];
      `ALU_SLL:    return a << b[5:0];
      `ALU_SRA:    return word_t'($signed(a) >>> b[5:0]);
      `ALU_CMPEQ:  return (a == b) ? 64'd1 : 64'd0;
      `ALU_CMPLT:  return ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
      `ALU_CMPULT: return (a < b) ? 64'd1 : 64'd0;
      `ALU_MULQ:   return a * b;   // Low 64 bits
      default:     return '0;
    endcase
  endfunction

  function logic cond_holds(input logic [2:0] c, input word_t r);
    logic neg, zero;
    neg  = r[63];
    zero = (r == 64'd0);
    case (c)
      `BR_LBC: return !r[0];
      `BR_EQ:  return zero;
      `BR_LT:  return neg;
      `BR_LE:  return neg || zero;
      `BR_LBS: return r[0];
      `BR_NE:  return !zero;
      `BR_GE:  return !neg;
      default: return !neg && !zero;
    endcase
  endfunction

  task automatic drive_lane(input int ln, input alu_func_t f, input opa_sel_t sa,
                            input opb_sel_t sb, input logic cb, input logic ub,
                            input logic rd, input logic wr);
    word_t t, a, b, ra, res;
    instr_t w;
    logic tk;
    exp_t e;
    t  = next_random();
    w  = t[63:32];
    ra = (random_below(4) == 0) ? 64'd0 : next_random();   // Zero now and then for branch tests
    e.dest  = reg_idx_t'(random_below(32));
    e.npc   = next_random() & ~64'h3;
    e.pht   = pht_idx_t'(random_below(256));
    regb[ln] <= lcg_state;
    a = (sa == `OPA_IS_MEM_DISP) ? {{48{w[15]}}, w[15:0]} :
        (sa == `OPA_IS_NPC) ? e.npc : ra;
    b = (sb == `OPB_IS_ALU_IMM) ? {56'd0, w[20:13]} :
        (sb == `OPB_IS_BR_DISP) ? {{41{w[20]}}, w[20:0], 2'b00} : lcg_state;
    res = alu_model(f, a, b);
    tk  = ub || (cb && cond_holds(w[28:26], ra));
    t   = (random_below(2) == 0) ? res : next_random();   // Predicted target right half the time
    valid_in[ln] <= 1'b1;
    npc[ln] <= e.npc;
    ppc[ln] <= t;
    pht_idx[ln] <= e.pht;
    ir[ln] <= w;
    dest_reg[ln] <= e.dest;
    rega[ln] <= ra;
    opa_select[ln] <= sa;
    opb_select[ln] <= sb;
    alu_func[ln] <= f;
    cond_branch[ln] <= cb;
    uncond_branch[ln] <= ub;
    rd_mem[ln] <= rd;
    wr_mem[ln] <= wr;
    e.kind   = (f == `ALU_MULQ) ? 2'd1 : 2'd0;
    e.result = res;
    e.br     = {cb | ub, tk};
    e.mis    = tk && (res != t);
    e.exact  = exact_mode;
    e.due    = cyc + ((f == `ALU_MULQ) ? 7 : 3);
    if (rd || wr)
    begin
      lsq_exp_addr = res;
      lsq_exp_val  = ra;
      lsq_exp_tag  = e.dest;
    end
    else
      exp_q[ln].push_back(e);
  endtask

  task automatic idle_lanes();
    for (int i = 0; i < `EX_LANES; i++)
      valid_in[i] <= 1'b0;
  endtask

  //////////////////////////////
  // Result checking
  always @(negedge clock)
  begin
    exp_t e;
    for (int i = 0; i < `EX_LANES; i++)
    begin
      head_ok[i] = 1'b1;
      if (stall_bus[i])
        saw_stall = 1'b1;
      if (rst_n && ex_valid[i])
      begin
        if (exp_q[i].size() == 0)
        begin
          head_ok[i] = 1'b0;
          err_msg[i] = $sformatf("lane %0d result with nothing expected", i);
        end
        else
        begin
          e = exp_q[i].pop_front();
          if (ex_result[i] !== e.result || ex_dest_reg[i] !== e.dest)
            head_ok[i] = 1'b0;
          if (e.kind != 2'd2 && ex_npc[i] !== e.npc)
            head_ok[i] = 1'b0;
          if (e.kind != 2'd2 && (ex_branch_result[i] !== e.br || ex_mispredict[i] !== e.mis))
            head_ok[i] = 1'b0;
          if (e.kind == 2'd0 && e.br[1] && ex_pht_idx[i] !== e.pht)
            head_ok[i] = 1'b0;
          if (e.exact && cyc != e.due)
            head_ok[i] = 1'b0;
          err_msg[i] = $sformatf("lane %0d got %h dest %0d, expected %h dest %0d at cycle %0d",
                                 i, ex_result[i], ex_dest_reg[i], e.result, e.dest, e.due);
        end
      end
    end
  end

  for (genvar g = 0; g < `EX_LANES; g++)
  begin : g_chk
    a_result: assert property (@(posedge clock) disable iff (!rst_n) head_ok[g])
      else fail_now(err_msg[g]);
  end

  //////////////////////////////
  // Stimulus
  initial
  begin
    alu_func_t funcs [12] = '{`ALU_ADDQ, `ALU_SUBQ, `ALU_AND, `ALU_BIC, `ALU_BIS, `ALU_XOR,
                              `ALU_SRL, `ALU_SLL, `ALU_SRA, `ALU_CMPEQ, `ALU_CMPLT,
                              `ALU_CMPULT};
    logic ub;
    reg_idx_t ret_tag;
    word_t ret_value;
    exp_t ret_exp;
    rst_n = 1'b0;
    mem_valid = 1'b0;
    mem_tag = '0;
    mem_value = '0;
    exact_mode = 1'b1;
    saw_stall = 1'b0;
    for (int i = 0; i < `EX_LANES; i++)
    begin
      valid_in[i] = 1'b0;
      npc[i] = '0;
      ppc[i] = '0;
      pht_idx[i] = '0;
      ir[i] = '0;
      dest_reg[i] = '0;
      rega[i] = '0;
      regb[i] = '0;
      opa_select[i] = '0;
      opb_select[i] = '0;
      alu_func[i] = '0;
      cond_branch[i] = 1'b0;
      uncond_branch[i] = 1'b0;
      rd_mem[i] = 1'b0;
      wr_mem[i] = 1'b0;
    end
    repeat (8) @(posedge clock);
    rst_n <= 1'b1;
    @(negedge clock);
    for (int i = 0; i < `EX_LANES; i++)
      assert (!ex_valid[i] && !lsq_valid[i] && !stall_bus[i])
        else fail_now("outputs not low after reset");

    // ALU ops, register and immediate operands
    for (int n = 0; n < 20; n++)
    begin
      @(posedge clock);
      for (int i = 0; i < `EX_LANES; i++)
        drive_lane(i, funcs[random_below(12)], `OPA_IS_REGA, opb_sel_t'(random_below(2)),
                   0, 0, 0, 0);
    end

    // Branches
    for (int n = 0; n < 16; n++)
    begin
      @(posedge clock);
      ub = (random_below(3) == 0);
      for (int i = 0; i < `EX_LANES; i++)
        drive_lane(i, `ALU_ADDQ, `OPA_IS_NPC, `OPB_IS_BR_DISP, !ub, ub, 0, 0);
    end
    @(posedge clock);
    idle_lanes();
    repeat (3) @(posedge clock);

    // Loads and stores raise lsq_valid for one cycle only
    for (int n = 0; n < 8; n++)
    begin
      drive_lane(n % 2, `ALU_ADDQ, `OPA_IS_MEM_DISP, `OPB_IS_REGB, 0, 0, n < 4, n >= 4);
      @(posedge clock);
      idle_lanes();
      @(negedge clock);
      assert (lsq_valid[n % 2] && lsq_address[n % 2] == lsq_exp_addr
              && lsq_value[n % 2] == lsq_exp_val && lsq_tag[n % 2] == lsq_exp_tag)
        else fail_now("LSQ outputs wrong for memory op");
      @(negedge clock);
      assert (!lsq_valid[n % 2]) else fail_now("lsq_valid held for more than one cycle");
      @(posedge clock);
    end

    // Back-to-back multiplies on both lanes
    for (int n = 0; n < 6; n++)
    begin
      @(posedge clock);
      for (int i = 0; i < `EX_LANES; i++)
        drive_lane(i, `ALU_MULQ, `OPA_IS_REGA, `OPB_IS_REGB, 0, 0, 0, 0);
    end
    @(posedge clock);
    idle_lanes();
    repeat (8) @(posedge clock);

    // Memory return, product and ALU op all want the last slot
    exact_mode = 1'b0;
    saw_stall = 1'b0;
    ret_tag = reg_idx_t'(random_below(32));
    ret_value = next_random();
    mem_tag <= ret_tag;
    mem_value <= ret_value;
    ret_exp = '{kind: 2'd2, dest: ret_tag, npc: '0, result: ret_value,
                br: '0, mis: 1'b0, pht: '0, exact: 1'b0, due: 0};
    exp_q[`EX_LANES-1].push_back(ret_exp);
    drive_lane(`EX_LANES-1, `ALU_MULQ, `OPA_IS_REGA, `OPB_IS_REGB, 0, 0, 0, 0);
    @(posedge clock);
    idle_lanes();
    repeat (3) @(posedge clock);
    drive_lane(`EX_LANES-1, `ALU_XOR, `OPA_IS_REGA, `OPB_IS_REGB, 0, 0, 0, 0);
    @(posedge clock);
    idle_lanes();
    mem_valid <= 1'b1;
    @(posedge clock);
    mem_valid <= 1'b0;
    repeat (10) @(posedge clock);
    assert (saw_stall) else fail_now("stall_bus never rose in the conflict test");

    if (exp_q[0].size() == 0 && exp_q[1].size() == 0)
    begin
      $display("Verification passed");
      $finish;
    end
    else
    begin
      $display("Results missing at the end of the run");
      $display("Verification failed");
      $fatal(1);
    end
  end

endmodule
